// ==== Makefile ====
# Verilator lint and simulation of the rasterizer core

BIN = obj_dir/raster_sim

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f tb.f --top-module raster_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module raster_tb -o raster_sim
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== bench/raster_chk.sv ====
// --------------------------------------------------
// concurrent assertions on the credit counter,
// pipeline latency and reset state of the core
// --------------------------------------------------

`timescale 1ns/1ps

`include "raster_params.svh"

module raster_chk #(
	parameter int CREDIT_WIDTH = $clog2(`RASTER_CREDITS + 1)
) (
	input logic                    clk,
	input logic                    reset,
	input logic                    issue,
	input logic [CREDIT_WIDTH-1:0] credit_cnt,
	input logic                    out_valid,
	input logic                    busy
);

	// counter never above the sink's grant
	credit_bound: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= CREDIT_WIDTH'(`RASTER_CREDITS))
		else $error("credit count %0d above the grant", credit_cnt);

	// issue register follows a cycle that held a credit
	issue_with_credit: assert property (@(posedge clk) disable iff (reset)
		issue |-> ($past(credit_cnt) != '0))
		else $error("pixel issued with no credit");

	// beats leave exactly four cycles after issue
	output_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid == $past(issue, 4))
		else $error("out_valid does not follow issue by four cycles");

	busy_after_reset: assert property (@(posedge clk)
		reset |=> !busy)
		else $error("busy high after reset");

endmodule

bind raster_core raster_chk chk_i (
	.clk        (clk),
	.reset      (reset),
	.issue      (issue),
	.credit_cnt (timing_gen_i.credit_cnt),
	.out_valid  (out_valid),
	.busy       (busy)
);

// ==== bench/raster_stim.txt ====
// one test per four lines, all values hex
//   width height cull credit_quarters region{poly1,poly0}
//   edge_coef[0..3] as dx_dy_offset
//   poly_coef[0..1] as dx_dy_offset
//   expected: beats covered index0 index1 attr_sum frame_end_pos
// scan order and plane sum, polygon 0 covers the whole frame
05 03 1 4 0000
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0002_fff6_0005 0001_0001_0100
18 18 18 0 ffffff88 17
// culling, front only
03 02 1 4 c033
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0000_0000_0007 0000_0000_0020
0c 02 02 0 0000000e 0b
// culling, back only
03 02 2 4 c033
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0000_0000_0007 0000_0000_0020
0c 04 04 0 0000001c 0b
// culling, both faces
03 02 3 4 c033
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0000_0000_0007 0000_0000_0020
0c 06 06 0 0000002a 0b
// overlapping polygons, full credit
03 02 1 4 2011
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0001_0010_0100 0002_0000_0200
0c 0a 06 4 00000e77 0b
// same overlap with credits returned one time in four
03 02 1 1 2011
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0001_0010_0100 0002_0000_0200
0c 0a 06 4 00000e77 0b
// single pixel frame, back faces accepted
00 00 2 2 0000
0001_0000_fffe 0000_0001_ffff 0000_0000_ffff 0000_0000_0000
0003_0004_1234 0000_0000_0000
01 01 01 0 00001234 00

// ==== bench/raster_tb.sv ====
// --------------------------------------------------
// rasterizer testbench: frames from the stim file,
// random credit return, per beat flag checks and
// per frame summary checks
// --------------------------------------------------

`timescale 1ns/1ps

`include "raster_params.svh"

module raster_tb;

	import raster_pkg::*;

	localparam int NUM_TESTS    = 7;
	localparam int REC_WORDS    = 17;
	localparam int CYCLE_MARGIN = 1000;
	localparam int DRAIN_CYCLES = 12;

	// word offsets inside one record
	localparam int W_WIDTH  = 0;
	localparam int W_HEIGHT = 1;
	localparam int W_CULL   = 2;
	localparam int W_CREDIT = 3;
	localparam int W_REGION = 4;
	localparam int W_EDGE   = 5;
	localparam int W_POLY   = 9;
	localparam int W_EXP    = 11;

	logic                                    clk;
	logic                                    reset;
	logic                                    start;
	logic                                    busy;
	logic [`RASTER_X_WIDTH-1:0]              width;
	logic [`RASTER_Y_WIDTH-1:0]              height;
	cull_mode_t                              cull;
	plane_coef_t [`RASTER_EDGE_NUM-1:0]      edge_coef;
	plane_coef_t [`RASTER_POLY_NUM-1:0]      poly_coef;
	region_mask_t [`RASTER_POLY_NUM-1:0]     region;
	logic                                    credit_return;
	logic                                    out_valid;
	raster_beat_t                            out_beat;

	logic [47:0] stim [0:NUM_TESTS*REC_WORDS-1];

	int                 test_num        = 0;
	int                 errors          = 0;
	int                 cycles          = 0;
	int                 cycle_limit     = 0;
	int                 credit_quarters = 4;
	int                 arrived         = 0;
	int                 returned        = 0;
	int                 beat_cnt;
	int                 cover_cnt;
	int                 index_cnt [`RASTER_POLY_NUM];
	int                 fe_pos;
	logic signed [31:0] attr_sum;
	bit                 frame_done;

	raster_core raster_core_i (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.busy          (busy),
		.width         (width),
		.height        (height),
		.cull          (cull),
		.edge_coef     (edge_coef),
		.poly_coef     (poly_coef),
		.region        (region),
		.credit_return (credit_return),
		.out_valid     (out_valid),
		.out_beat      (out_beat)
	);

	always #2 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("[ERROR] test %0d %s: got 0x%h, expected 0x%h",
				test_num, name, got, expected);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// sink: count beats, check flags, return credits
	// --------------------------------------------------
	always @(negedge clk) begin
		logic [2:0] exp_ctl;
		int         frame_beats;
		int         px;
		int         py;
		coef_t      exp_attr;
		if (!reset && out_valid) begin
			frame_beats = (int'(width) + 1) * (int'(height) + 1);
			px = beat_cnt % (int'(width) + 1);
			py = beat_cnt / (int'(width) + 1);
			exp_ctl = {beat_cnt == 0,
				(beat_cnt % (int'(width) + 1)) == int'(width),
				beat_cnt == frame_beats - 1};
			check_value("out_beat.ctl", 32'(out_beat.ctl), 32'(exp_ctl));
			if (`RASTER_CREDITS + returned - arrived <= 0) begin
				$display("test %0d: beat arrived while the core held no credit", test_num);
				errors++;
			end
			if (out_beat.covered) begin
				cover_cnt++;
				index_cnt[out_beat.index]++;
				attr_sum += 32'($signed(out_beat.attr));
			end else begin
				// uncovered beats carry polygon 0 at this pixel
				exp_attr = coef_t'(poly_coef[0].offset + px * poly_coef[0].dx
					+ py * poly_coef[0].dy);
				check_value("out_beat.index", 32'(out_beat.index), 32'(0));
				check_value("out_beat.attr", 32'(out_beat.attr), 32'(exp_attr));
			end
			if (out_beat.ctl.frame_end) begin
				fe_pos     = beat_cnt;
				frame_done = 1'b1;
			end
			beat_cnt++;
			arrived++;
		end
	end

	always @(posedge clk) begin
		if (reset) begin
			credit_return <= 1'b0;
		end else if (arrived > returned && ($urandom % 4) < credit_quarters) begin
			credit_return <= 1'b1;
			returned++;
		end else begin
			credit_return <= 1'b0;
		end
	end

	// cycle limit from the total beat count
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout after %0d cycles, test %0d did not finish", cycles, test_num);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// one frame per record
	// --------------------------------------------------
	task automatic run_test(input int t);
		int base;
		base     = t * REC_WORDS;
		test_num = t + 1;
		while (busy || arrived != returned) @(negedge clk);
		beat_cnt   = 0;
		cover_cnt  = 0;
		index_cnt  = '{default: 0};
		fe_pos     = -1;
		attr_sum   = '0;
		frame_done = 1'b0;
		credit_quarters = int'(stim[base+W_CREDIT]);
		@(posedge clk);
		width  <= stim[base+W_WIDTH][`RASTER_X_WIDTH-1:0];
		height <= stim[base+W_HEIGHT][`RASTER_Y_WIDTH-1:0];
		cull   <= stim[base+W_CULL][1:0];
		region <= stim[base+W_REGION][15:0];
		for (int e = 0; e < `RASTER_EDGE_NUM; e++) begin
			edge_coef[e] <= stim[base+W_EDGE+e];
		end
		for (int p = 0; p < `RASTER_POLY_NUM; p++) begin
			poly_coef[p] <= stim[base+W_POLY+p];
		end
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// a second start while busy must not add a frame
		do @(negedge clk); while (!busy);
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		while (!frame_done) @(posedge clk);
		@(negedge clk);
		if (busy) begin
			$display("test %0d: busy still high one cycle after the last beat", test_num);
			errors++;
		end
		repeat (DRAIN_CYCLES) @(negedge clk);
		check_value("beat_count", beat_cnt, stim[base+W_EXP][31:0]);
		check_value("covered_count", cover_cnt, stim[base+W_EXP+1][31:0]);
		check_value("index0_count", index_cnt[0], stim[base+W_EXP+2][31:0]);
		check_value("index1_count", index_cnt[1], stim[base+W_EXP+3][31:0]);
		check_value("attr_sum", attr_sum, stim[base+W_EXP+4][31:0]);
		check_value("frame_end_pos", fe_pos, stim[base+W_EXP+5][31:0]);
	endtask

	initial begin
		int total_beats;
		int err_before;
		int passed;
		int failed;
		void'($urandom(32'h9668_2110));
		$readmemh("bench/raster_stim.txt", stim);
		total_beats = 0;
		passed      = 0;
		failed      = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total_beats += int'(stim[t*REC_WORDS+W_EXP]);
		end
		cycle_limit = 64 * total_beats + CYCLE_MARGIN;

		clk           = 1'b0;
		reset         = 1'b1;
		start         = 1'b0;
		width         = '0;
		height        = '0;
		cull          = '0;
		edge_coef     = '0;
		poly_coef     = '0;
		region        = '0;
		credit_return = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		for (int t = 0; t < NUM_TESTS; t++) begin
			err_before = errors;
			run_test(t);
			if (errors == err_before) begin
				passed++;
				$display("test %0d passed: %0d beats, %0d covered", t + 1, beat_cnt, cover_cnt);
			end else begin
				failed++;
				$display("test %0d failed: %0d beats, %0d covered", t + 1, beat_cnt, cover_cnt);
			end
		end

		$display("%0d tests: %0d passed, %0d failed, %0d errors",
			NUM_TESTS, passed, failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== src/raster_core.sv ====
// --------------------------------------------------
// rasterizer top: timing, plane evaluators, region
// test and polygon select, plus busy tracking
// --------------------------------------------------

`timescale 1ns/1ps

`include "raster_params.svh"

module raster_core (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic                                              start,
	output logic                                              busy,
	input  logic [`RASTER_X_WIDTH-1:0]                        width,
	input  logic [`RASTER_Y_WIDTH-1:0]                        height,
	input  raster_pkg::cull_mode_t                            cull,
	input  raster_pkg::plane_coef_t [`RASTER_EDGE_NUM-1:0]    edge_coef,
	input  raster_pkg::plane_coef_t [`RASTER_POLY_NUM-1:0]    poly_coef,
	input  raster_pkg::region_mask_t [`RASTER_POLY_NUM-1:0]   region,
	input  logic                                              credit_return,
	output logic                                              out_valid,
	output raster_pkg::raster_beat_t                          out_beat
);

	import raster_pkg::*;

	// edges only need the sign
	typedef logic signed [`RASTER_COEF_WIDTH-1:0] edge_val_t;

	logic                          start_ok;
	logic                          issue;
	logic                          x_first;
	logic                          y_first;
	pixel_ctl_t                    issue_ctl;
	logic                          scanning;

	logic                          calc_valid;
	pixel_ctl_t                    calc_ctl;
	logic [`RASTER_EDGE_NUM-1:0]   edge_sign;
	coef_t [`RASTER_POLY_NUM-1:0]  poly_value;
	coef_t [`RASTER_POLY_NUM-1:0]  attr_align;

	logic                          region_valid;
	pixel_ctl_t                    region_ctl;
	logic [`RASTER_POLY_NUM-1:0]   covered;
	logic                          select_pending;

	// a new frame only from idle
	assign start_ok = start && !busy;

	raster_timing_gen timing_gen_i (
		.clk           (clk),
		.reset         (reset),
		.start         (start_ok),
		.width         (width),
		.height        (height),
		.credit_return (credit_return),
		.issue         (issue),
		.x_first       (x_first),
		.y_first       (y_first),
		.ctl           (issue_ctl),
		.scanning      (scanning)
	);

	// --------------------------------------------------
	// plane evaluation
	// --------------------------------------------------
	for (genvar e = 0; e < `RASTER_EDGE_NUM; e++) begin : g_edge
		edge_val_t edge_value;

		raster_plane_calc #(
			.value_t (edge_val_t)
		) edge_calc_i (
			.clk     (clk),
			.reset   (reset),
			.issue   (issue),
			.x_first (x_first),
			.y_first (y_first),
			.coef    (edge_coef[e]),
			.value   (edge_value)
		);

		assign edge_sign[e] = edge_value[`RASTER_COEF_WIDTH-1];
	end

	for (genvar p = 0; p < `RASTER_POLY_NUM; p++) begin : g_poly
		raster_plane_calc #(
			.value_t (coef_t)
		) poly_calc_i (
			.clk     (clk),
			.reset   (reset),
			.issue   (issue),
			.x_first (x_first),
			.y_first (y_first),
			.coef    (poly_coef[p]),
			.value   (poly_value[p])
		);
	end

	// flags follow the evaluators by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			calc_valid <= 1'b0;
		end else begin
			calc_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		calc_ctl   <= issue_ctl;
		// line attributes up with the region result
		attr_align <= poly_value;
	end

	raster_region_test region_test_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (calc_valid),
		.in_ctl    (calc_ctl),
		.edge_sign (edge_sign),
		.region    (region),
		.cull      (cull),
		.out_valid (region_valid),
		.out_ctl   (region_ctl),
		.covered   (covered)
	);

	raster_polygon_select polygon_select_i (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (region_valid),
		.in_ctl    (region_ctl),
		.covered   (covered),
		.attr      (attr_align),
		.out_valid (out_valid),
		.beat      (out_beat)
	);

	// --------------------------------------------------
	// busy: scan running or any beat still in flight
	// --------------------------------------------------

	// mirrors the selector's inner stage
	always_ff @(posedge clk) begin
		if (reset) begin
			select_pending <= 1'b0;
		end else begin
			select_pending <= region_valid;
		end
	end

	assign busy = scanning | issue | calc_valid | region_valid | select_pending | out_valid;

endmodule

// ==== src/raster_params.svh ====
// --------------------------------------------------
// rasterizer constants: coordinate widths, edge and
// polygon counts, plane value width, credit depth
// --------------------------------------------------

`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// pixel coordinate counters
`define RASTER_X_WIDTH 6
`define RASTER_Y_WIDTH 6

// geometry
`define RASTER_EDGE_NUM 4
`define RASTER_POLY_NUM 2
`define RASTER_POLY_INDEX_WIDTH 1

// signed plane values and coefficients
`define RASTER_COEF_WIDTH 16

// credits granted by the sink after reset
`define RASTER_CREDITS 4

`endif

// ==== src/raster_pkg.sv ====
// --------------------------------------------------
// rasterizer types: plane coefficients, region masks,
// culling mode and the pipeline beat
// --------------------------------------------------

`include "raster_params.svh"

package raster_pkg;

	// signed plane value, wraps at its width
	typedef logic signed [`RASTER_COEF_WIDTH-1:0] coef_t;

	// one plane: value at (x,y) is offset + x*dx + y*dy
	typedef struct packed {
		coef_t dx;
		coef_t dy;
		coef_t offset;
	} plane_coef_t;

	// per polygon edge selection and expected sign
	typedef struct packed {
		logic [`RASTER_EDGE_NUM-1:0] used;
		logic [`RASTER_EDGE_NUM-1:0] polarity;
	} region_mask_t;

	// position flags travelling with a pixel
	typedef struct packed {
		logic frame_start;
		logic line_end;
		logic frame_end;
	} pixel_ctl_t;

	// output beat
	typedef struct packed {
		pixel_ctl_t                           ctl;
		logic                                 covered;
		logic [`RASTER_POLY_INDEX_WIDTH-1:0]  index;
		coef_t                                attr;
	} raster_beat_t;

	// bit 0 accepts front facing, bit 1 back facing
	typedef logic [1:0] cull_mode_t;

endpackage

// ==== src/raster_plane_calc.sv ====
// --------------------------------------------------
// incremental plane evaluator, value type is a
// parameter so edges and attributes share it
// --------------------------------------------------

`timescale 1ns/1ps

module raster_plane_calc #(
	parameter type value_t = raster_pkg::coef_t
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    issue,
	input  logic                    x_first,
	input  logic                    y_first,
	input  raster_pkg::plane_coef_t coef,
	output value_t                  value
);

	// value at x = 0 of the current line
	value_t line_base;

	always_ff @(posedge clk) begin
		if (reset) begin
			line_base <= '0;
			value     <= '0;
		end else if (issue) begin
			if (x_first) begin
				if (y_first) begin
					// top left corner of the frame
					line_base <= value_t'(coef.offset);
					value     <= value_t'(coef.offset);
				end else begin
					line_base <= line_base + value_t'(coef.dy);
					value     <= line_base + value_t'(coef.dy);
				end
			end else begin
				// step along the line
				value <= value + value_t'(coef.dx);
			end
		end
	end

endmodule

// ==== src/raster_polygon_select.sv ====
// --------------------------------------------------
// two stage selector: lowest covering polygon index,
// then its attribute
// --------------------------------------------------

`timescale 1ns/1ps

`include "raster_params.svh"

module raster_polygon_select (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       in_valid,
	input  raster_pkg::pixel_ctl_t                     in_ctl,
	input  logic [`RASTER_POLY_NUM-1:0]                covered,
	input  raster_pkg::coef_t [`RASTER_POLY_NUM-1:0]   attr,
	output logic                                       out_valid,
	output raster_pkg::raster_beat_t                   beat
);

	import raster_pkg::*;

	logic [`RASTER_POLY_INDEX_WIDTH-1:0] first_index;

	// stage 0 registers
	logic                                s0_valid;
	pixel_ctl_t                          s0_ctl;
	logic                                s0_any;
	logic [`RASTER_POLY_INDEX_WIDTH-1:0] s0_index;
	coef_t [`RASTER_POLY_NUM-1:0]        s0_attr;

	// lowest index wins, 0 when nothing covers
	always_comb begin
		first_index = '0;
		for (int i = `RASTER_POLY_NUM - 1; i >= 0; i--) begin
			if (covered[i]) begin
				first_index = `RASTER_POLY_INDEX_WIDTH'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s0_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			s0_valid  <= in_valid;
			out_valid <= s0_valid;
		end
	end

	// --------------------------------------------------
	// payload: encode, then pick the attribute
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		s0_ctl       <= in_ctl;
		s0_any       <= |covered;
		s0_index     <= first_index;
		s0_attr      <= attr;

		beat.ctl     <= s0_ctl;
		beat.covered <= s0_any;
		beat.index   <= s0_index;
		beat.attr    <= s0_attr[s0_index];
	end

endmodule

// ==== src/raster_region_test.sv ====
// --------------------------------------------------
// per polygon region test on edge signs, with
// front/back face culling
// --------------------------------------------------

`timescale 1ns/1ps

`include "raster_params.svh"

module raster_region_test (
	input  logic                                              clk,
	input  logic                                              reset,
	input  logic                                              in_valid,
	input  raster_pkg::pixel_ctl_t                            in_ctl,
	input  logic [`RASTER_EDGE_NUM-1:0]                       edge_sign,
	input  raster_pkg::region_mask_t [`RASTER_POLY_NUM-1:0]   region,
	input  raster_pkg::cull_mode_t                            cull,
	output logic                                              out_valid,
	output raster_pkg::pixel_ctl_t                            out_ctl,
	output logic [`RASTER_POLY_NUM-1:0]                       covered
);

	logic [`RASTER_POLY_NUM-1:0] front;
	logic [`RASTER_POLY_NUM-1:0] back;
	logic [`RASTER_POLY_NUM-1:0] hit;

	for (genvar i = 0; i < `RASTER_POLY_NUM; i++) begin : g_poly
		// front: every used edge matches its polarity
		assign front[i] = &(~(edge_sign ^ region[i].polarity) | ~region[i].used);
		// back: no used edge matches
		assign back[i]  = ~|(~(edge_sign ^ region[i].polarity) & region[i].used);
		assign hit[i]   = (front[i] & cull[0]) | (back[i] & cull[1]);
	end

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_ctl <= in_ctl;
		covered <= hit;
	end

endmodule

// ==== src/raster_timing_gen.sv ====
// --------------------------------------------------
// frame scan: x/y counters, start and scanning flag,
// credit counter gating pixel issue
// --------------------------------------------------

`timescale 1ns/1ps

`include "raster_params.svh"

module raster_timing_gen (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        start,
	input  logic [`RASTER_X_WIDTH-1:0]  width,
	input  logic [`RASTER_Y_WIDTH-1:0]  height,
	input  logic                        credit_return,
	output logic                        issue,
	output logic                        x_first,
	output logic                        y_first,
	output raster_pkg::pixel_ctl_t      ctl,
	output logic                        scanning
);

	localparam int CREDIT_WIDTH = $clog2(`RASTER_CREDITS + 1);

	logic [`RASTER_X_WIDTH-1:0] x;
	logic [`RASTER_Y_WIDTH-1:0] y;
	logic [CREDIT_WIDTH-1:0]    credit_cnt;
	logic                       fire;
	logic                       at_frame_start;
	logic                       at_line_end;
	logic                       at_frame_end;

	// a pixel goes out only while scanning with a credit in hand
	assign fire           = scanning && (credit_cnt != '0);
	assign at_frame_start = (x == '0) && (y == '0);
	assign at_line_end    = (x == width);
	assign at_frame_end   = at_line_end && (y == height);

	// --------------------------------------------------
	// scan counters
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			scanning <= 1'b0;
			x        <= '0;
			y        <= '0;
		end else if (!scanning) begin
			scanning <= start;
			x        <= '0;
			y        <= '0;
		end else if (fire) begin
			if (at_line_end) begin
				x <= '0;
				if (at_frame_end) begin
					y        <= '0;
					scanning <= 1'b0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// issue outputs, one cycle after the decision
	always_ff @(posedge clk) begin
		if (reset) begin
			issue <= 1'b0;
		end else begin
			issue <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			x_first         <= (x == '0);
			y_first         <= at_frame_start;
			ctl.frame_start <= at_frame_start;
			ctl.line_end    <= at_line_end;
			ctl.frame_end   <= at_frame_end;
		end
	end

	// --------------------------------------------------
	// credits: spend on issue, refill on return
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			credit_cnt <= CREDIT_WIDTH'(`RASTER_CREDITS);
		end else begin
			credit_cnt <= credit_cnt - CREDIT_WIDTH'(fire) + CREDIT_WIDTH'(credit_return);
		end
	end

endmodule

// ==== tb.f ====
+incdir+src
src/raster_pkg.sv
src/raster_timing_gen.sv
src/raster_plane_calc.sv
src/raster_region_test.sv
src/raster_polygon_select.sv
src/raster_core.sv
bench/raster_chk.sv
bench/raster_tb.sv
